// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - include_dirs:
      - source
    files:
      - source/rv_pkg.sv
      - source/rv_decoder.sv
      - source/id_issue.sv
      - source/id_stage.sv
  - target: test
    include_dirs:
      - source
      - testbench
    files:
      - testbench/tb_id_stage.sv

// ==== flist.f ====
+incdir+source
+incdir+testbench
source/rv_pkg.sv
source/rv_decoder.sv
source/id_issue.sv
source/id_stage.sv
testbench/tb_id_stage.sv

// ==== source/id_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module id_issue import rv_pkg::*; (
    input  wire                clk_i,
    input  wire                rst_n_i,
    input  wire decoded_t      dec_i,
    input  wire [`XLEN-1:0]    rf1_data_i,
    input  wire [`XLEN-1:0]    rf2_data_i,
    input  wire fwd_t          ex_fwd_i,
    input  wire fwd_t          mem_fwd_i,
    output rf_req_t            rf1_req_o,
    output rf_req_t            rf2_req_o,
    output logic               stall_o,
    output id_ex_t             id_ex_o
);

    localparam id_ex_t BUBBLE = '0;

    logic [`XLEN-1:0] reg1;
    logic [`XLEN-1:0] reg2;
    id_ex_t           id_ex_d;

    // load still in EX, data not available yet
    function automatic logic load_hit(input rf_req_t req, input fwd_t ex);
        load_hit = req.read && ex.ld && (ex.wd == req.addr);
    endfunction

    // r0 is not special here, a write to x0 still forwards
    function automatic logic [`XLEN-1:0] operand(input rf_req_t req,
                                                 input logic [`XLEN-1:0] imm,
                                                 input logic [`XLEN-1:0] rf_data,
                                                 input fwd_t ex,
                                                 input fwd_t mem);
        if (!req.read) begin
            operand = imm;
        end else if (load_hit(req, ex)) begin
            operand = '0;
        end else if (ex.wreg && ex.wd == req.addr) begin
            operand = ex.wdata;
        end else if (mem.wreg && mem.wd == req.addr) begin
            operand = mem.wdata;
        end else begin
            operand = rf_data;
        end
    endfunction

    assign rf1_req_o = dec_i.rf1;
    assign rf2_req_o = dec_i.rf2;

    assign stall_o = load_hit(dec_i.rf1, ex_fwd_i) || load_hit(dec_i.rf2, ex_fwd_i);

    assign reg1 = operand(dec_i.rf1, dec_i.imm, rf1_data_i, ex_fwd_i, mem_fwd_i);
    assign reg2 = operand(dec_i.rf2, dec_i.imm, rf2_data_i, ex_fwd_i, mem_fwd_i);

    always_comb begin
        id_ex_d.pc       = dec_i.pc;
        id_ex_d.aluop    = dec_i.aluop;
        id_ex_d.alusel   = dec_i.alusel;
        id_ex_d.reg1     = reg1;
        id_ex_d.reg2     = reg2;
        id_ex_d.wd       = dec_i.rd;
        id_ex_d.wreg     = dec_i.wreg;
        id_ex_d.b_flag   = dec_i.b_flag;
        id_ex_d.b_target = dec_i.b_target;
        // third operand for stores and loads
        id_ex_d.offset   = dec_i.imm;
    end

    // ID/EX register, a stalled cycle sends a bubble down
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || stall_o) begin
            id_ex_o <= BUBBLE;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module id_stage import rv_pkg::*; (
    input  wire                clk_i,
    input  wire                rst_n_i,

    // fetch side
    input  wire [`XLEN-1:0]    pc_i,
    input  wire inst_t         inst_i,

    // register file, read data comes back in the same cycle
    output rf_req_t            rf1_req_o,
    output rf_req_t            rf2_req_o,
    input  wire [`XLEN-1:0]    rf1_data_i,
    input  wire [`XLEN-1:0]    rf2_data_i,

    // bypass from later stages
    input  wire fwd_t          ex_fwd_i,
    input  wire fwd_t          mem_fwd_i,

    output logic               stall_o,
    output id_ex_t             id_ex_o
);

    decoded_t dec;

    rv_decoder u_decoder (
        .pc_i   (pc_i),
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    id_issue u_issue (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .dec_i      (dec),
        .rf1_data_i (rf1_data_i),
        .rf2_data_i (rf2_data_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .rf1_req_o  (rf1_req_o),
        .rf2_req_o  (rf2_req_o),
        .stall_o    (stall_o),
        .id_ex_o    (id_ex_o)
    );

endmodule

`default_nettype wire

// ==== source/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decoder import rv_pkg::*; (
    input  wire [`XLEN-1:0] pc_i,
    input  wire inst_t      inst_i,
    output decoded_t        dec_o
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_sh;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [2:0]       f3;
    logic [6:0]       f7;

    assign f3 = inst_i.r.funct3;
    assign f7 = inst_i.r.funct7;

    assign imm_i  = {{(`XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_sh = {{(`XLEN-5){1'b0}}, inst_i.i.imm[4:0]};
    assign imm_s  = {{(`XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    assign imm_b  = {{(`XLEN-13){inst_i.b.imm_12}}, inst_i.b.imm_12, inst_i.b.imm_11,
                     inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
    assign imm_u  = {inst_i.u.imm, 12'h000};
    assign imm_j  = {{(`XLEN-21){inst_i.j.imm_20}}, inst_i.j.imm_20, inst_i.j.imm_19_12,
                     inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};

    // shared by OP and OP-IMM, SUB only exists in the register form
    function automatic alu_op_e arith_op(input logic [2:0] fn3, input logic [6:0] fn7,
                                         input logic is_reg);
        arith_op = ALU_NOP;
        case (fn3)
            `F3_ADD_SUB: begin
                if (!is_reg || fn7 == `F7_BASE) begin
                    arith_op = ALU_ADD;
                end else if (fn7 == `F7_ALT) begin
                    arith_op = ALU_SUB;
                end
            end
            `F3_SLT:  arith_op = ALU_SLT;
            `F3_SLTU: arith_op = ALU_SLTU;
            `F3_XOR:  arith_op = ALU_XOR;
            `F3_OR:   arith_op = ALU_OR;
            `F3_AND:  arith_op = ALU_AND;
            `F3_SLL:  arith_op = ALU_SLL;
            `F3_SRL_SRA: begin
                if (fn7 == `F7_BASE) begin
                    arith_op = ALU_SRL;
                end else if (fn7 == `F7_ALT) begin
                    arith_op = ALU_SRA;
                end
            end
            default: arith_op = ALU_NOP;
        endcase
    endfunction

    function automatic res_sel_e group_of(input alu_op_e op);
        case (op)
            ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AUIPC: group_of = RES_ARITH;
            ALU_XOR, ALU_OR, ALU_AND:                       group_of = RES_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:                      group_of = RES_SHIFT;
            ALU_LW, ALU_SW:                                 group_of = RES_LD_ST;
            ALU_JAL, ALU_JALR:                              group_of = RES_JAL;
            default:                                        group_of = RES_NOP;
        endcase
    endfunction

    always_comb begin
        dec_o          = '0;
        dec_o.pc       = pc_i;
        dec_o.rd       = inst_i.r.rd;
        dec_o.rf1.addr = inst_i.r.rs1;
        dec_o.rf2.addr = inst_i.r.rs2;
        dec_o.aluop    = ALU_NOP;

        case (inst_i.r.opcode)
            OPC_OPI: begin
                dec_o.aluop    = arith_op(f3, f7, 1'b0);
                dec_o.wreg     = 1'b1;
                dec_o.rf1.read = 1'b1;
                // shift amount is the low five bits only
                dec_o.imm      = (f3 == `F3_SLL || f3 == `F3_SRL_SRA) ? imm_sh : imm_i;
            end
            OPC_OP: begin
                dec_o.aluop    = arith_op(f3, f7, 1'b1);
                dec_o.wreg     = 1'b1;
                dec_o.rf1.read = 1'b1;
                dec_o.rf2.read = 1'b1;
            end
            OPC_LOAD: begin
                if (f3 == `F3_LW) begin
                    dec_o.aluop = ALU_LW;
                end
                dec_o.wreg     = 1'b1;
                dec_o.rf1.read = 1'b1;
                dec_o.imm      = imm_i;
            end
            OPC_STORE: begin
                if (f3 == `F3_SW) begin
                    dec_o.aluop = ALU_SW;
                end
                dec_o.rf1.read = 1'b1;
                dec_o.rf2.read = 1'b1;
                dec_o.imm      = imm_s;
            end
            OPC_BRANCH: begin
                case (f3)
                    `F3_BEQ:  dec_o.aluop = ALU_BEQ;
                    `F3_BNE:  dec_o.aluop = ALU_BNE;
                    `F3_BLT:  dec_o.aluop = ALU_BLT;
                    `F3_BGE:  dec_o.aluop = ALU_BGE;
                    `F3_BLTU: dec_o.aluop = ALU_BLTU;
                    `F3_BGEU: dec_o.aluop = ALU_BGEU;
                    default:  dec_o.aluop = ALU_NOP;
                endcase
                dec_o.rf1.read = 1'b1;
                dec_o.rf2.read = 1'b1;
                dec_o.imm      = imm_b;
            end
            OPC_JAL: begin
                dec_o.aluop    = ALU_JAL;
                dec_o.wreg     = 1'b1;
                dec_o.imm      = imm_j;
                dec_o.b_flag   = 1'b1;
                dec_o.b_target = pc_i + imm_j;
            end
            OPC_JALR: begin
                dec_o.aluop    = ALU_JALR;
                dec_o.wreg     = 1'b1;
                dec_o.rf1.read = 1'b1;
                dec_o.imm      = imm_i;
            end
            OPC_LUI: begin
                // executed as 0 | imm in the logic unit
                dec_o.aluop = ALU_OR;
                dec_o.wreg  = 1'b1;
                dec_o.imm   = imm_u;
            end
            OPC_AUIPC: begin
                dec_o.aluop = ALU_AUIPC;
                dec_o.wreg  = 1'b1;
                dec_o.imm   = imm_u;
            end
            default: begin
                dec_o.aluop = ALU_NOP;
            end
        endcase

        // unknown sub-encodings collapse to a nop
        if (dec_o.aluop == ALU_NOP) begin
            dec_o.wreg     = 1'b0;
            dec_o.rf1.read = 1'b0;
            dec_o.rf2.read = 1'b0;
            dec_o.imm      = '0;
            dec_o.b_flag   = 1'b0;
            dec_o.b_target = '0;
        end

        dec_o.alusel = group_of(dec_o.aluop);
    end

endmodule

`default_nettype wire

// ==== source/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define ALU_OP_W    5
`define RES_SEL_W   3

// funct3, OP and OP-IMM
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3, word load and store only
`define F3_LW       3'b010
`define F3_SW       3'b010

// funct3, conditional branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// funct7, SUB and SRA use the alternate form
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

// bubble encodings
`define ALU_OP_NOP  5'd0
`define RES_SEL_NOP 3'd0

`endif

// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

`include "rv_defs.svh"

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OPI    = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // views of the fetched word, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_t;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_NOP = `ALU_OP_NOP,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LW, ALU_SW,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_JAL, ALU_JALR, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [`RES_SEL_W-1:0] {
        RES_NOP = `RES_SEL_NOP,
        RES_ARITH, RES_LOGIC, RES_SHIFT, RES_LD_ST, RES_JAL
    } res_sel_e;

    typedef struct packed {
        logic                   read;
        logic [`REG_ADDR_W-1:0] addr;
    } rf_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        alu_op_e                aluop;
        res_sel_e               alusel;
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] rd;
        rf_req_t                rf1;
        rf_req_t                rf2;
        logic [`XLEN-1:0]       imm;
        logic                   b_flag;
        logic [`XLEN-1:0]       b_target;
    } decoded_t;

    // ld is only meaningful on the EX source
    typedef struct packed {
        logic                   wreg;
        logic                   ld;
        logic [`REG_ADDR_W-1:0] wd;
        logic [`XLEN-1:0]       wdata;
    } fwd_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        alu_op_e                aluop;
        res_sel_e               alusel;
        logic [`XLEN-1:0]       reg1;
        logic [`XLEN-1:0]       reg2;
        logic [`REG_ADDR_W-1:0] wd;
        logic                   wreg;
        logic                   b_flag;
        logic [`XLEN-1:0]       b_target;
        logic [`XLEN-1:0]       offset;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== testbench/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// register file model, x0 reads as zero
logic [`XLEN-1:0] rf_mem [0:31];

task automatic fill_rf();
    rf_mem[0] = '0;
    for (int i = 1; i < 32; i++) begin
        rf_mem[i] = $urandom;
    end
endtask

// instruction encoders, field order as in the ISA manual
function automatic inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                input logic [4:0] rs1, input logic [2:0] f3,
                                input logic [4:0] rd, input logic [6:0] opc);
    enc_r = {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                input logic [2:0] f3, input logic [4:0] rd,
                                input logic [6:0] opc);
    enc_i = {imm, rs1, f3, rd, opc};
endfunction

function automatic inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                input logic [4:0] rs1, input logic [2:0] f3);
    enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                input logic [4:0] rs1, input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic inst_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                input logic [6:0] opc);
    enc_u = {imm, rd, opc};
endfunction

function automatic inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic rf_req_t make_req(input logic read, input logic [4:0] addr);
    make_req.read = read;
    make_req.addr = addr;
endfunction

// expected ID/EX bundle, operands already resolved by the caller
function automatic id_ex_t expect_issue(input logic [31:0] pc, input alu_op_e op,
                                        input res_sel_e sel, input logic [31:0] reg1,
                                        input logic [31:0] reg2, input logic [4:0] wd,
                                        input logic wreg, input logic b_flag,
                                        input logic [31:0] b_target,
                                        input logic [31:0] offset);
    expect_issue.pc       = pc;
    expect_issue.aluop    = op;
    expect_issue.alusel   = sel;
    expect_issue.reg1     = reg1;
    expect_issue.reg2     = reg2;
    expect_issue.wd       = wd;
    expect_issue.wreg     = wreg;
    expect_issue.b_flag   = b_flag;
    expect_issue.b_target = b_target;
    expect_issue.offset   = offset;
endfunction

`endif

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_id_stage import rv_pkg::*; ();

    // 45 issues of two cycles each plus reset need under 100 cycles
    localparam int MAX_CYCLES = 400;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] pc;
    inst_t            inst;
    fwd_t             ex_fwd;
    fwd_t             mem_fwd;
    rf_req_t          rf1_req;
    rf_req_t          rf2_req;
    logic [`XLEN-1:0] rf1_data;
    logic [`XLEN-1:0] rf2_data;
    logic             stall;
    id_ex_t           id_ex;
    int               errors;
    int               cycles;

`include "tb_ref_model.svh"

    id_stage dut0 (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .pc_i       (pc),
        .inst_i     (inst),
        .rf1_req_o  (rf1_req),
        .rf2_req_o  (rf2_req),
        .rf1_data_i (rf1_data),
        .rf2_data_i (rf2_data),
        .ex_fwd_i   (ex_fwd),
        .mem_fwd_i  (mem_fwd),
        .stall_o    (stall),
        .id_ex_o    (id_ex)
    );

    // asynchronous register file read
    assign rf1_data = rf_mem[rf1_req.addr];
    assign rf2_data = rf_mem[rf2_req.addr];

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_id_ex(input string name, input id_ex_t exp, input id_ex_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // address of an unread port is a don't care
    task automatic check_rf_req(input string name, input rf_req_t exp, input rf_req_t act);
        if (act.read !== exp.read || (exp.read && act.addr !== exp.addr)) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s stall: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    function automatic fwd_t mk_fwd(input logic wreg, input logic ld, input logic [4:0] wd,
                                    input logic [31:0] data);
        mk_fwd.wreg  = wreg;
        mk_fwd.ld    = ld;
        mk_fwd.wd    = wd;
        mk_fwd.wdata = data;
    endfunction

    // requests and stall checked in the drive cycle and the bundle one edge later
    task automatic run_inst(input string name, input inst_t w, input logic [31:0] w_pc,
                            input fwd_t ex, input fwd_t mem, input rf_req_t r1,
                            input rf_req_t r2, input logic st, input id_ex_t exp);
        @(posedge clk);
        inst    <= w;
        pc      <= w_pc;
        ex_fwd  <= ex;
        mem_fwd <= mem;
        @(negedge clk);
        check_rf_req({name, " rf1"}, r1, rf1_req);
        check_rf_req({name, " rf2"}, r2, rf2_req);
        check_stall(name, st, stall);
        @(negedge clk);
        check_id_ex(name, exp, id_ex);
    endtask

    task automatic alu_r_case(input string name, input logic [2:0] f3, input logic [6:0] f7,
                              input alu_op_e op, input res_sel_e sel);
        inst_t  w;
        id_ex_t e;
        w = enc_r(f7, 5'd7, 5'd3, f3, 5'd10, OPC_OP);
        e = expect_issue(32'h40, op, sel, rf_mem[3], rf_mem[7], 5'd10, 1'b1, 1'b0, '0, '0);
        run_inst(name, w, 32'h40, '0, '0, make_req(1, 3), make_req(1, 7), 1'b0, e);
    endtask

    task automatic alu_i_case(input string name, input logic [2:0] f3, input logic [11:0] imm,
                              input alu_op_e op, input res_sel_e sel,
                              input logic [31:0] exp_imm);
        inst_t  w;
        id_ex_t e;
        w = enc_i(imm, 5'd4, f3, 5'd11, OPC_OPI);
        e = expect_issue(32'h44, op, sel, rf_mem[4], exp_imm, 5'd11, 1'b1, 1'b0, '0, exp_imm);
        run_inst(name, w, 32'h44, '0, '0, make_req(1, 4), make_req(0, 0), 1'b0, e);
    endtask

    task automatic fwd_case(input string name, input logic [4:0] rs1, input logic [4:0] rs2,
                            input fwd_t ex, input fwd_t mem, input logic [31:0] exp1,
                            input logic [31:0] exp2);
        inst_t  w;
        id_ex_t e;
        w = enc_r(`F7_BASE, rs2, rs1, `F3_ADD_SUB, 5'd12, OPC_OP);
        e = expect_issue(32'h80, ALU_ADD, RES_ARITH, exp1, exp2, 5'd12, 1'b1, 1'b0, '0, '0);
        run_inst(name, w, 32'h80, ex, mem, make_req(1, rs1), make_req(1, rs2), 1'b0, e);
    endtask

    task automatic branch_case(input string name, input logic [2:0] f3, input alu_op_e op,
                               input logic [12:0] imm, input logic [31:0] exp_imm);
        inst_t  w;
        id_ex_t e;
        w = enc_b(imm, 5'd7, 5'd3, f3);
        e = expect_issue(32'hb0, op, RES_NOP, rf_mem[3], rf_mem[7], w[11:7], 1'b0, 1'b0,
                         '0, exp_imm);
        run_inst(name, w, 32'hb0, '0, '0, make_req(1, 3), make_req(1, 7), 1'b0, e);
    endtask

    task automatic reset_bubble();
        check_id_ex("reset", '0, id_ex);
    endtask

    task automatic alu_ops();
        inst_t  w;
        id_ex_t e;
        alu_r_case("add", `F3_ADD_SUB, `F7_BASE, ALU_ADD, RES_ARITH);
        alu_r_case("sub", `F3_ADD_SUB, `F7_ALT, ALU_SUB, RES_ARITH);
        alu_r_case("slt", `F3_SLT, `F7_BASE, ALU_SLT, RES_ARITH);
        alu_r_case("sltu", `F3_SLTU, `F7_BASE, ALU_SLTU, RES_ARITH);
        alu_r_case("xor", `F3_XOR, `F7_BASE, ALU_XOR, RES_LOGIC);
        alu_r_case("or", `F3_OR, `F7_BASE, ALU_OR, RES_LOGIC);
        alu_r_case("and", `F3_AND, `F7_BASE, ALU_AND, RES_LOGIC);
        alu_r_case("sll", `F3_SLL, `F7_BASE, ALU_SLL, RES_SHIFT);
        alu_r_case("srl", `F3_SRL_SRA, `F7_BASE, ALU_SRL, RES_SHIFT);
        alu_r_case("sra", `F3_SRL_SRA, `F7_ALT, ALU_SRA, RES_SHIFT);
        alu_i_case("addi", `F3_ADD_SUB, 12'hffb, ALU_ADD, RES_ARITH, 32'hfffffffb);
        alu_i_case("slti", `F3_SLT, 12'h7ff, ALU_SLT, RES_ARITH, 32'h000007ff);
        alu_i_case("sltiu", `F3_SLTU, 12'h800, ALU_SLTU, RES_ARITH, 32'hfffff800);
        alu_i_case("xori", `F3_XOR, 12'h0f0, ALU_XOR, RES_LOGIC, 32'h000000f0);
        alu_i_case("ori", `F3_OR, 12'h123, ALU_OR, RES_LOGIC, 32'h00000123);
        alu_i_case("andi", `F3_AND, 12'hfff, ALU_AND, RES_LOGIC, 32'hffffffff);
        alu_i_case("slli", `F3_SLL, 12'h005, ALU_SLL, RES_SHIFT, 32'd5);
        alu_i_case("srli", `F3_SRL_SRA, 12'h01f, ALU_SRL, RES_SHIFT, 32'd31);
        alu_i_case("srai", `F3_SRL_SRA, 12'h409, ALU_SRA, RES_SHIFT, 32'd9);
        // lui runs as an or with both operands the immediate
        w = enc_u(20'habcde, 5'd5, OPC_LUI);
        e = expect_issue(32'h48, ALU_OR, RES_LOGIC, 32'habcde000, 32'habcde000, 5'd5, 1'b1,
                         1'b0, '0, 32'habcde000);
        run_inst("lui", w, 32'h48, '0, '0, make_req(0, 0), make_req(0, 0), 1'b0, e);
        w = enc_u(20'h80001, 5'd6, OPC_AUIPC);
        e = expect_issue(32'h4c, ALU_AUIPC, RES_ARITH, 32'h80001000, 32'h80001000, 5'd6, 1'b1,
                         1'b0, '0, 32'h80001000);
        run_inst("auipc", w, 32'h4c, '0, '0, make_req(0, 0), make_req(0, 0), 1'b0, e);
    endtask

    task automatic forwarding_priority();
        fwd_case("fwd rs1 ex over mem", 3, 7, mk_fwd(1, 0, 3, 32'hee01),
                 mk_fwd(1, 0, 3, 32'hdd01), 32'hee01, rf_mem[7]);
        fwd_case("fwd rs1 mem", 3, 7, '0, mk_fwd(1, 0, 3, 32'hdd02), 32'hdd02, rf_mem[7]);
        fwd_case("fwd rs1 rf", 3, 7, mk_fwd(1, 0, 9, 32'hee03), mk_fwd(1, 0, 10, 32'hdd03),
                 rf_mem[3], rf_mem[7]);
        fwd_case("fwd rs2 ex over mem", 3, 7, mk_fwd(1, 0, 7, 32'hee04),
                 mk_fwd(1, 0, 7, 32'hdd04), rf_mem[3], 32'hee04);
        fwd_case("fwd rs2 mem", 3, 7, '0, mk_fwd(1, 0, 7, 32'hdd05), rf_mem[3], 32'hdd05);
        fwd_case("fwd rs2 rf", 3, 7, mk_fwd(0, 0, 7, 32'hee06), mk_fwd(0, 0, 7, 32'hdd06),
                 rf_mem[3], rf_mem[7]);
        fwd_case("fwd ex without wreg", 3, 7, mk_fwd(0, 0, 3, 32'hee07),
                 mk_fwd(1, 0, 3, 32'hdd07), 32'hdd07, rf_mem[7]);
        // x0 gets no special treatment
        fwd_case("fwd x0", 0, 7, mk_fwd(1, 0, 0, 32'h5a5a), '0, 32'h5a5a, rf_mem[7]);
    endtask

    task automatic load_use_stall();
        inst_t  w;
        id_ex_t e;
        w = enc_r(`F7_BASE, 5'd7, 5'd3, `F3_ADD_SUB, 5'd12, OPC_OP);
        run_inst("load-use rs1", w, 32'h90, mk_fwd(1, 1, 3, 32'h1111), '0, make_req(1, 3),
                 make_req(1, 7), 1'b1, '0);
        // load has moved on to MEM
        e = expect_issue(32'h90, ALU_ADD, RES_ARITH, 32'h2222, rf_mem[7], 5'd12, 1'b1, 1'b0,
                         '0, '0);
        run_inst("load-use rs1 release", w, 32'h90, '0, mk_fwd(1, 0, 3, 32'h2222),
                 make_req(1, 3), make_req(1, 7), 1'b0, e);
        run_inst("load-use rs2", w, 32'h90, mk_fwd(1, 1, 7, 32'h3333), '0, make_req(1, 3),
                 make_req(1, 7), 1'b1, '0);
        e = expect_issue(32'h90, ALU_ADD, RES_ARITH, rf_mem[3], 32'h4444, 5'd12, 1'b1, 1'b0,
                         '0, '0);
        run_inst("load-use rs2 release", w, 32'h90, mk_fwd(1, 0, 7, 32'h4444), '0,
                 make_req(1, 3), make_req(1, 7), 1'b0, e);
    endtask

    task automatic mem_and_control();
        inst_t  w;
        id_ex_t e;
        w = enc_i(12'hff8, 5'd4, `F3_LW, 5'd13, OPC_LOAD);
        e = expect_issue(32'ha0, ALU_LW, RES_LD_ST, rf_mem[4], 32'hfffffff8, 5'd13, 1'b1, 1'b0,
                         '0, 32'hfffffff8);
        run_inst("lw", w, 32'ha0, '0, '0, make_req(1, 4), make_req(0, 0), 1'b0, e);
        w = enc_s(12'd20, 5'd7, 5'd3, `F3_SW);
        e = expect_issue(32'ha4, ALU_SW, RES_LD_ST, rf_mem[3], rf_mem[7], w[11:7], 1'b0, 1'b0,
                         '0, 32'd20);
        run_inst("sw", w, 32'ha4, '0, '0, make_req(1, 3), make_req(1, 7), 1'b0, e);
        branch_case("beq", `F3_BEQ, ALU_BEQ, 13'h0008, 32'h00000008);
        branch_case("bne", `F3_BNE, ALU_BNE, 13'h1ff0, 32'hfffffff0);
        branch_case("blt", `F3_BLT, ALU_BLT, 13'h0ffe, 32'h00000ffe);
        branch_case("bge", `F3_BGE, ALU_BGE, 13'h1000, 32'hfffff000);
        branch_case("bltu", `F3_BLTU, ALU_BLTU, 13'h0804, 32'h00000804);
        branch_case("bgeu", `F3_BGEU, ALU_BGEU, 13'h1ffe, 32'hfffffffe);
        w = enc_j(21'h000800, 5'd1);
        e = expect_issue(32'h100, ALU_JAL, RES_JAL, 32'h800, 32'h800, 5'd1, 1'b1, 1'b1,
                         32'h900, 32'h800);
        run_inst("jal fwd", w, 32'h100, '0, '0, make_req(0, 0), make_req(0, 0), 1'b0, e);
        w = enc_j(21'h1ffffc, 5'd1);
        e = expect_issue(32'h100, ALU_JAL, RES_JAL, 32'hfffffffc, 32'hfffffffc, 5'd1, 1'b1,
                         1'b1, 32'h0fc, 32'hfffffffc);
        run_inst("jal back", w, 32'h100, '0, '0, make_req(0, 0), make_req(0, 0), 1'b0, e);
        w = enc_i(12'd12, 5'd4, 3'b000, 5'd1, OPC_JALR);
        e = expect_issue(32'h104, ALU_JALR, RES_JAL, rf_mem[4], 32'd12, 5'd1, 1'b1, 1'b0,
                         '0, 32'd12);
        run_inst("jalr", w, 32'h104, '0, '0, make_req(1, 4), make_req(0, 0), 1'b0, e);
    endtask

    task automatic unknown_opcode();
        inst_t  w;
        id_ex_t e;
        w = enc_r(`F7_BASE, 5'd7, 5'd3, 3'b000, 5'd9, 7'h7f);
        e = expect_issue(32'hc0, ALU_NOP, RES_NOP, '0, '0, 5'd9, 1'b0, 1'b0, '0, '0);
        // pending load on rs1 must not stall a nop
        run_inst("unknown opcode", w, 32'hc0, mk_fwd(1, 1, 3, 32'h5555), '0, make_req(0, 0),
                 make_req(0, 0), 1'b0, e);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        // a live add during reset, only the reset can turn it into a bubble
        pc      = 32'h20;
        inst    = enc_r(`F7_BASE, 5'd7, 5'd3, `F3_ADD_SUB, 5'd12, OPC_OP);
        ex_fwd  = '0;
        mem_fwd = '0;
        errors  = 0;
        cycles  = 0;
        void'($urandom(32'hbc5cb468));
        fill_rf();

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        reset_bubble();
        alu_ops();
        forwarding_priority();
        load_use_stall();
        mem_and_control();
        unknown_opcode();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
